// File: verilog/sccb_config.svh
`ifndef SCCB_CONFIG_SVH
`define SCCB_CONFIG_SVH

////////////////////
// Frame type bytes

// Header byte sits in lane 0 of the first word of every frame
`define SCCB_TYPE_APB_WRITE	8'hfb
`define SCCB_TYPE_APB_READ	8'h1c
`define SCCB_TYPE_COMP_DATA	8'hfd
`define SCCB_TYPE_COMP_EMPTY	8'hf7

// Sequence number byte, lane 1, always zero for now
`define SCCB_SEQ_NONE	8'h00

////////////////////
// Widths

`define SCCB_ADDR_WIDTH	32
`define SCCB_DATA_WIDTH	32
`define SCCB_WORD_BYTES	4

// Valid byte counts seen on the link
`define SCCB_NVALID_FULL	3'd4
`define SCCB_NVALID_HALF	3'd2
`define SCCB_NVALID_STATUS	3'd3

`endif

// File: verilog/sccb_pkg.sv
`default_nettype none
`include "sccb_config.svh"

package sccb_pkg;

	// One word from or to the link layer, lane 0 in the low byte
	typedef logic [8*`SCCB_WORD_BYTES-1:0] link_word_t;

	// Count of valid bytes in a link word, 0 to 4
	typedef logic [$clog2(`SCCB_WORD_BYTES+1)-1:0] byte_count_t;

	// APB payload types
	typedef logic [`SCCB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`SCCB_DATA_WIDTH-1:0] apb_data_t;
	typedef logic [`SCCB_DATA_WIDTH/8-1:0] apb_strb_t;

	// Request frame parser, one state per word
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_WR_ADDR,
		DEC_WR_DATA,
		DEC_RD_ADDR,
		DEC_WAIT_VERDICT
	} decode_state_t;

	// APB requester phases
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

	// Completion frame output
	typedef enum logic {
		ENC_IDLE,
		ENC_SECOND
	} encode_state_t;

endpackage

`default_nettype wire

// File: verilog/sccb_ifs.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////
// Link receive words

interface rx_link_if;
	logic link_up;
	logic start;
	logic valid;
	sccb_pkg::byte_count_t nvalid;
	sccb_pkg::link_word_t data;
	logic commit;
	logic drop;

	modport source (output link_up, start, valid, nvalid, data, commit, drop);
	modport sink (input link_up, start, valid, nvalid, data, commit, drop);
endinterface

////////////////////
// Decoded APB command

interface apb_cmd_if;
	// Single cycle strobe, fields stay stable while it is high
	logic cmd_valid;
	logic write;
	sccb_pkg::apb_addr_t addr;
	sccb_pkg::apb_data_t wdata;
	sccb_pkg::apb_strb_t strb;
	// Requester has a transfer or completion in flight
	logic busy;

	modport source (output cmd_valid, write, addr, wdata, strb, input busy);
	modport sink (input cmd_valid, write, addr, wdata, strb, output busy);
endinterface

////////////////////
// APB result

interface cpl_if;
	logic cpl_valid;
	logic has_data;
	logic success;
	sccb_pkg::apb_data_t data;

	modport source (output cpl_valid, has_data, success, data);
	modport sink (input cpl_valid, has_data, success, data);
endinterface

`default_nettype wire

// File: verilog/sccb_frame_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "sccb_config.svh"

module sccb_frame_decoder (
	input wire rx_clk,
	input wire rst_n,
	rx_link_if.sink link,
	apb_cmd_if.source cmd
);

	sccb_pkg::decode_state_t state;

	// Continuation word with no stray start or verdict alongside
	logic mid_word_ok;

	// Type byte of the first word
	logic is_write;

	assign mid_word_ok = link.valid && !link.start && !link.commit && !link.drop;
	assign is_write = (link.data[7:0] == `SCCB_TYPE_APB_WRITE);

	////////////////////
	// Frame state machine

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= sccb_pkg::DEC_IDLE;
			cmd.cmd_valid <= 1'b0;
		end else begin
			cmd.cmd_valid <= 1'b0;
			case (state)
				sccb_pkg::DEC_IDLE: begin
					// Only a full first word can open a request
					if (link.start && link.valid && !cmd.busy &&
						link.nvalid == `SCCB_NVALID_FULL) begin
						case (link.data[7:0])
							`SCCB_TYPE_APB_WRITE: state <= sccb_pkg::DEC_WR_ADDR;
							`SCCB_TYPE_APB_READ: state <= sccb_pkg::DEC_RD_ADDR;
							// Completions and unknown types are skipped
							default: state <= sccb_pkg::DEC_IDLE;
						endcase
					end
				end
				sccb_pkg::DEC_WR_ADDR: begin
					if (mid_word_ok && link.nvalid == `SCCB_NVALID_FULL)
						state <= sccb_pkg::DEC_WR_DATA;
					else
						state <= sccb_pkg::DEC_IDLE;
				end
				sccb_pkg::DEC_WR_DATA,
				sccb_pkg::DEC_RD_ADDR: begin
					// Last word carries two bytes
					if (mid_word_ok && link.nvalid == `SCCB_NVALID_HALF)
						state <= sccb_pkg::DEC_WAIT_VERDICT;
					else
						state <= sccb_pkg::DEC_IDLE;
				end
				sccb_pkg::DEC_WAIT_VERDICT: begin
					if (link.commit && !link.drop) begin
						// Hand the command on unless the requester is still working
						cmd.cmd_valid <= link.link_up && !cmd.busy;
						state <= sccb_pkg::DEC_IDLE;
					end else if (link.drop || link.valid || link.start) begin
						// Dropped, or extra words, either way the frame is gone
						state <= sccb_pkg::DEC_IDLE;
					end
				end
				default: state <= sccb_pkg::DEC_IDLE;
			endcase

			// Link down kills any frame in progress
			if (!link.link_up)
				state <= sccb_pkg::DEC_IDLE;
		end
	end

	////////////////////
	// Byte lane capture

	always_ff @(posedge rx_clk) begin
		case (state)
			sccb_pkg::DEC_IDLE: begin
				if (link.start) begin
					// Lanes 2 and 3 hold the high address half, MSB first
					cmd.addr[31:24] <= link.data[23:16];
					cmd.addr[23:16] <= link.data[31:24];
					cmd.write <= is_write;
					cmd.strb <= is_write ? '1 : '0;
					cmd.wdata <= '0;
				end
			end
			sccb_pkg::DEC_WR_ADDR: begin
				cmd.addr[15:8] <= link.data[7:0];
				cmd.addr[7:0] <= link.data[15:8];
				cmd.wdata[31:24] <= link.data[23:16];
				cmd.wdata[23:16] <= link.data[31:24];
			end
			sccb_pkg::DEC_WR_DATA: begin
				cmd.wdata[15:8] <= link.data[7:0];
				cmd.wdata[7:0] <= link.data[15:8];
			end
			sccb_pkg::DEC_RD_ADDR: begin
				cmd.addr[15:8] <= link.data[7:0];
				cmd.addr[7:0] <= link.data[15:8];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/sccb_apb_requester.sv
`timescale 1ns/1ns
`default_nettype none

module sccb_apb_requester (
	input wire rx_clk,
	input wire rst_n,
	apb_cmd_if.sink cmd,
	cpl_if.source cpl,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output sccb_pkg::apb_addr_t paddr,
	output sccb_pkg::apb_data_t pwdata,
	output sccb_pkg::apb_strb_t pstrb,
	input wire pready,
	input wire sccb_pkg::apb_data_t prdata,
	input wire pslverr
);

	sccb_pkg::apb_state_t state;

	// Busy from setup until the completion strobe has gone out
	assign cmd.busy = (state != sccb_pkg::APB_IDLE) || cpl.cpl_valid;

	////////////////////
	// APB phases

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= sccb_pkg::APB_IDLE;
			psel <= 1'b0;
			penable <= 1'b0;
			cpl.cpl_valid <= 1'b0;
		end else begin
			cpl.cpl_valid <= 1'b0;
			case (state)
				sccb_pkg::APB_IDLE: begin
					if (cmd.cmd_valid) begin
						psel <= 1'b1;
						state <= sccb_pkg::APB_SETUP;
					end
				end
				// Setup is always exactly one cycle
				sccb_pkg::APB_SETUP: begin
					penable <= 1'b1;
					state <= sccb_pkg::APB_ACCESS;
				end
				// Completer stretches this with pready low
				sccb_pkg::APB_ACCESS: begin
					if (pready) begin
						psel <= 1'b0;
						penable <= 1'b0;
						cpl.cpl_valid <= 1'b1;
						state <= sccb_pkg::APB_IDLE;
					end
				end
				default: state <= sccb_pkg::APB_IDLE;
			endcase
		end
	end

	////////////////////
	// Command and result latches

	always_ff @(posedge rx_clk) begin
		// Decoder only strobes when we are idle
		if (cmd.cmd_valid && state == sccb_pkg::APB_IDLE) begin
			pwrite <= cmd.write;
			paddr <= cmd.addr;
			pwdata <= cmd.wdata;
			pstrb <= cmd.strb;
		end
		if (state == sccb_pkg::APB_ACCESS && pready) begin
			// Failed reads return no data, just the error status
			cpl.has_data <= !pwrite && !pslverr;
			cpl.success <= !pslverr;
			cpl.data <= prdata;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sccb_completion_encoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "sccb_config.svh"

module sccb_completion_encoder (
	input wire rx_clk,
	input wire rst_n,
	cpl_if.sink cpl,
	output logic tx_ll_start,
	output sccb_pkg::byte_count_t tx_ll_nvalid,
	output sccb_pkg::link_word_t tx_ll_data
);

	sccb_pkg::encode_state_t state;

	// Low data half, sent in the second word of a data completion
	logic [15:0] low_half;

	////////////////////
	// Completion words

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= sccb_pkg::ENC_IDLE;
			tx_ll_start <= 1'b0;
			tx_ll_nvalid <= '0;
			tx_ll_data <= '0;
		end else begin
			// Idle link cycles carry all zeros
			tx_ll_start <= 1'b0;
			tx_ll_nvalid <= '0;
			tx_ll_data <= '0;

			case (state)
				sccb_pkg::ENC_IDLE: begin
					if (cpl.cpl_valid) begin
						tx_ll_start <= 1'b1;
						tx_ll_data[15:8] <= `SCCB_SEQ_NONE;

						if (cpl.has_data) begin
							// Type, seq, then data MSB first
							tx_ll_nvalid <= `SCCB_NVALID_FULL;
							tx_ll_data[7:0] <= `SCCB_TYPE_COMP_DATA;
							tx_ll_data[23:16] <= cpl.data[31:24];
							tx_ll_data[31:24] <= cpl.data[23:16];
							state <= sccb_pkg::ENC_SECOND;
						end else begin
							// Status only, lane 2 is 1 on success
							tx_ll_nvalid <= `SCCB_NVALID_STATUS;
							tx_ll_data[7:0] <= `SCCB_TYPE_COMP_EMPTY;
							tx_ll_data[23:16] <= {7'd0, cpl.success};
						end
					end
				end

				// Tail of a data completion, two bytes
				sccb_pkg::ENC_SECOND: begin
					tx_ll_nvalid <= `SCCB_NVALID_HALF;
					tx_ll_data[7:0] <= low_half[15:8];
					tx_ll_data[15:8] <= low_half[7:0];
					state <= sccb_pkg::ENC_IDLE;
				end

				default: state <= sccb_pkg::ENC_IDLE;
			endcase
		end
	end

	////////////////////
	// Data hold

	// Only captured while idle, so the second word stays intact
	always_ff @(posedge rx_clk) begin
		if (cpl.cpl_valid && state == sccb_pkg::ENC_IDLE)
			low_half <= cpl.data[15:0];
	end

endmodule

`default_nettype wire

// File: verilog/sccb_apb_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module sccb_apb_bridge (
	input wire rx_clk,
	input wire rst_n,

	// Link layer receive side
	input wire rx_link_up,
	input wire rx_ll_start,
	input wire rx_ll_valid,
	input wire sccb_pkg::byte_count_t rx_ll_nvalid,
	input wire sccb_pkg::link_word_t rx_ll_data,
	input wire rx_ll_commit,
	input wire rx_ll_drop,

	// Link layer transmit side, no back-pressure
	output wire tx_ll_start,
	output wire sccb_pkg::byte_count_t tx_ll_nvalid,
	output wire sccb_pkg::link_word_t tx_ll_data,

	// APB requester
	output wire psel,
	output wire penable,
	output wire pwrite,
	output wire sccb_pkg::apb_addr_t paddr,
	output wire sccb_pkg::apb_data_t pwdata,
	output wire sccb_pkg::apb_strb_t pstrb,
	input wire pready,
	input wire sccb_pkg::apb_data_t prdata,
	input wire pslverr
);

	rx_link_if rx_link_i ();
	apb_cmd_if apb_cmd_i ();
	cpl_if cpl_i ();

	// Bundle the receive ports for the decoder
	assign rx_link_i.link_up = rx_link_up;
	assign rx_link_i.start = rx_ll_start;
	assign rx_link_i.valid = rx_ll_valid;
	assign rx_link_i.nvalid = rx_ll_nvalid;
	assign rx_link_i.data = rx_ll_data;
	assign rx_link_i.commit = rx_ll_commit;
	assign rx_link_i.drop = rx_ll_drop;

	sccb_frame_decoder decoder_i (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.link(rx_link_i.sink),
		.cmd(apb_cmd_i.source)
	);

	sccb_apb_requester requester_i (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.cmd(apb_cmd_i.sink),
		.cpl(cpl_i.source),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr)
	);

	sccb_completion_encoder encoder_i (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.cpl(cpl_i.sink),
		.tx_ll_start(tx_ll_start),
		.tx_ll_nvalid(tx_ll_nvalid),
		.tx_ll_data(tx_ll_data)
	);

endmodule

`default_nettype wire

// File: testbench/sccb_apb_bridge_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "sccb_config.svh"

module sccb_apb_bridge_tb;

	localparam int NUM_VECTORS = 16;
	localparam int CLK_HALF = 20;
	// Frame, access with up to three wait states and completion, with room to spare
	localparam int CYCLES_PER_VECTOR = 40;
	localparam int WATCHDOG_NS = (NUM_VECTORS * CYCLES_PER_VECTOR + 50) * 2 * CLK_HALF;

	logic rx_clk;
	logic rst_n;
	logic rx_link_up;
	logic rx_ll_start;
	logic rx_ll_valid;
	sccb_pkg::byte_count_t rx_ll_nvalid;
	sccb_pkg::link_word_t rx_ll_data;
	logic rx_ll_commit;
	logic rx_ll_drop;
	logic tx_ll_start;
	sccb_pkg::byte_count_t tx_ll_nvalid;
	sccb_pkg::link_word_t tx_ll_data;
	logic psel;
	logic penable;
	logic pwrite;
	sccb_pkg::apb_addr_t paddr;
	sccb_pkg::apb_data_t pwdata;
	sccb_pkg::apb_strb_t pstrb;
	logic pready;
	sccb_pkg::apb_data_t prdata;
	logic pslverr;

	// Kind, address, data, error flag, commit flag
	logic [75:0] vectors [0:NUM_VECTORS-1];
	// Completer memory, word index from paddr[5:2]
	logic [31:0] mem [0:15];
	logic [31:0] lcg_state;
	logic [1:0] wait_left;
	logic cur_err;
	int cycle = 0;
	int commit_cycle;
	int pready_cycle = -1;

	sccb_apb_bridge dut_i (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.rx_link_up(rx_link_up),
		.rx_ll_start(rx_ll_start),
		.rx_ll_valid(rx_ll_valid),
		.rx_ll_nvalid(rx_ll_nvalid),
		.rx_ll_data(rx_ll_data),
		.rx_ll_commit(rx_ll_commit),
		.rx_ll_drop(rx_ll_drop),
		.tx_ll_start(tx_ll_start),
		.tx_ll_nvalid(tx_ll_nvalid),
		.tx_ll_data(tx_ll_data),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr)
	);

	////////////////////
	// Clock and cycle count

	initial rx_clk = 1'b0;
	always #(CLK_HALF) rx_clk = ~rx_clk;

	always @(posedge rx_clk) cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	////////////////////
	// APB completer model

	initial begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		lcg_state = 32'ha3dd7126;
		wait_left = 2'd0;
		// Fill depends on every index bit
		for (int i = 0; i < 16; i++)
			mem[i] = 32'hc0de0000 | (i * 32'h111);
		forever begin
			@(posedge rx_clk);
			#1;
			// Setup phase picks the wait for this access
			if (psel && !penable) begin
				lcg_state = lcg_next(lcg_state);
				wait_left = lcg_state[17:16];
			end
			#1;
			pready = 1'b0;
			pslverr = 1'b0;
			prdata = '0;
			if (psel && penable) begin
				if (wait_left == 2'd0) begin
					pready = 1'b1;
					pslverr = cur_err;
					pready_cycle = cycle;
					if (!pwrite)
						prdata = mem[paddr[5:2]];
					else if (!cur_err)
						mem[paddr[5:2]] = pwdata;
				end else begin
					wait_left = wait_left - 2'd1;
				end
			end
		end
	end

	////////////////////
	// Link frame driver

	task automatic set_link_idle();
		rx_ll_start = 1'b0;
		rx_ll_valid = 1'b0;
		rx_ll_nvalid = '0;
		rx_ll_data = '0;
		rx_ll_commit = 1'b0;
		rx_ll_drop = 1'b0;
	endtask

	task automatic drive_word(input logic start, input sccb_pkg::byte_count_t nvalid,
		input sccb_pkg::link_word_t data);
		@(posedge rx_clk);
		#2;
		set_link_idle();
		rx_ll_start = start;
		rx_ll_valid = 1'b1;
		rx_ll_nvalid = nvalid;
		rx_ll_data = data;
	endtask

	// Verdict sits in its own cycle, link back up
	task automatic drive_verdict(input logic commit);
		@(posedge rx_clk);
		#2;
		set_link_idle();
		rx_link_up = 1'b1;
		rx_ll_commit = commit;
		rx_ll_drop = !commit;
		commit_cycle = cycle;
	endtask

	task automatic send_frame(input logic [3:0] kind, input logic [31:0] addr,
		input logic [31:0] data, input logic commit);
		logic is_read;
		is_read = (kind == 4'd1);
		// Type and sequence in lanes 0 and 1, address high half MSB first
		drive_word(1'b1, `SCCB_NVALID_FULL, {addr[23:16], addr[31:24], `SCCB_SEQ_NONE,
			is_read ? `SCCB_TYPE_APB_READ : `SCCB_TYPE_APB_WRITE});
		if (is_read) begin
			drive_word(1'b0, `SCCB_NVALID_HALF, {16'h0000, addr[7:0], addr[15:8]});
		end else begin
			drive_word(1'b0, `SCCB_NVALID_FULL, {data[23:16], data[31:24], addr[7:0], addr[15:8]});
			drive_word(1'b0, `SCCB_NVALID_HALF, {16'h0000, data[7:0], data[15:8]});
			// Link lost while the last word is on the wire
			if (kind == 4'd2)
				rx_link_up = 1'b0;
		end
		drive_verdict(commit);
	endtask

	////////////////////
	// One test case

	task automatic run_vector(input int n);
		logic [3:0] kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] err_f;
		logic [3:0] commit_f;
		logic is_write;
		logic [31:0] exp_rdata;
		logic seen_psel;
		logic tx_seen;
		if (^vectors[n] === 1'bx) begin
			$display("Vector %0d is missing or unreadable in the vector file", n);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
		{kind, addr, data, err_f, commit_f} = vectors[n];
		is_write = (kind != 4'd1);
		exp_rdata = mem[addr[5:2]];
		cur_err = err_f[0];
		send_frame(kind, addr, data, commit_f[0]);

		// Dropped or cut frames give no access and no completion
		if (!commit_f[0] || kind == 4'd2) begin
			repeat (12) begin
				@(posedge rx_clk);
				#1;
				check_value("psel", {31'd0, psel}, 32'd0);
				check_value("tx_ll_start", {31'd0, tx_ll_start}, 32'd0);
				#1;
				set_link_idle();
			end
			return;
		end

		seen_psel = 1'b0;
		tx_seen = 1'b0;
		while (!tx_seen) begin
			@(posedge rx_clk);
			#1;
			if (psel) begin
				if (!seen_psel) begin
					check_value("psel rise cycle", cycle, commit_cycle + 2);
					check_value("penable", {31'd0, penable}, 32'd0);
					seen_psel = 1'b1;
				end else begin
					check_value("penable", {31'd0, penable}, 32'd1);
				end
				// Access must end right after pready
				if (pready_cycle > commit_cycle && cycle > pready_cycle)
					check_value("psel", {31'd0, psel}, 32'd0);
				check_value("pwrite", {31'd0, pwrite}, {31'd0, is_write});
				check_value("paddr", paddr, addr);
				check_value("pstrb", {28'd0, pstrb}, is_write ? 32'h0000000f : 32'h0);
				if (is_write)
					check_value("pwdata", pwdata, data);
			end else begin
				check_value("penable", {31'd0, penable}, 32'd0);
			end
			if (tx_ll_start) begin
				tx_seen = 1'b1;
			end else begin
				#1;
				set_link_idle();
			end
		end
		check_value("psel seen", {31'd0, seen_psel}, 32'd1);
		check_value("tx_ll_start cycle", cycle, pready_cycle + 2);

		if (is_write || cur_err) begin
			// Status word, lane 2 is 1 on success
			check_value("tx_ll_nvalid", {29'd0, tx_ll_nvalid}, 32'd3);
			check_value("tx_ll_data", tx_ll_data, {8'h00, 7'd0, !cur_err,
				`SCCB_SEQ_NONE, `SCCB_TYPE_COMP_EMPTY});
		end else begin
			check_value("tx_ll_nvalid", {29'd0, tx_ll_nvalid}, 32'd4);
			check_value("tx_ll_data", tx_ll_data, {exp_rdata[23:16], exp_rdata[31:24],
				`SCCB_SEQ_NONE, `SCCB_TYPE_COMP_DATA});
			@(posedge rx_clk);
			#1;
			check_value("tx_ll_start", {31'd0, tx_ll_start}, 32'd0);
			check_value("tx_ll_nvalid", {29'd0, tx_ll_nvalid}, 32'd2);
			check_value("tx_ll_data", tx_ll_data, {16'h0000, exp_rdata[7:0], exp_rdata[15:8]});
		end
		// Transmit side back to all zeros
		@(posedge rx_clk);
		#1;
		check_value("tx_ll_start", {31'd0, tx_ll_start}, 32'd0);
		check_value("tx_ll_nvalid", {29'd0, tx_ll_nvalid}, 32'd0);
		check_value("tx_ll_data", tx_ll_data, 32'd0);
	endtask

	////////////////////
	// Main sequence

	initial begin
		rst_n = 1'b0;
		rx_link_up = 1'b1;
		cur_err = 1'b0;
		commit_cycle = 0;
		set_link_idle();
		$readmemh("testbench/sccb_vectors.txt", vectors);
		repeat (5) @(posedge rx_clk);
		#2;
		rst_n = 1'b1;
		for (int n = 0; n < NUM_VECTORS; n++)
			run_vector(n);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: testbench/sccb_vectors.txt
// One test per line: kind (0 write, 1 read, 2 write cut by link-down), address,
// write data, completer error flag, commit (1) or drop (0)
0_00000010_deadbeef_0_1
1_00000010_00000000_0_1
0_a5a50024_12345678_0_1
1_a5a50024_00000000_0_1
1_0000003c_00000000_0_1
0_00000008_cafef00d_1_1
1_00000008_00000000_0_1
1_00000004_00000000_1_1
0_00000020_0badf00d_0_0
1_00000020_00000000_0_1
2_00000030_11223344_0_1
0_00000030_55667788_0_1
1_00000030_00000000_0_1
1_ffff0000_00000000_0_0
0_ffff0000_a0b1c2d3_0_1
1_ffff0000_00000000_0_1

// File: sccb_apb_bridge.f
+incdir+verilog
verilog/sccb_pkg.sv
verilog/sccb_ifs.sv
verilog/sccb_frame_decoder.sv
verilog/sccb_apb_requester.sv
verilog/sccb_completion_encoder.sv
verilog/sccb_apb_bridge.sv
testbench/sccb_apb_bridge_tb.sv

// File: Makefile
# Verilator build and run for the APB bridge testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ns
TOP       := sccb_apb_bridge_tb
FILELIST  := sccb_apb_bridge.f
MDIR      := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: compile
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
